// File: project.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/control_unit.sv
logic/hazard_unit.sv
logic/datapath.sv
logic/run_control.sv
logic/cpu_top.sv
verif/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build the cpu testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module cpu_tb -f project.f --Mdir obj_dir -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: verif/cpu_tb.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_tb;
  import cpu_types_pkg::*;

  // rough sum of the cycles that all tests take.
  localparam int TEST_CYCLES = 450;
  localparam int RUN_LIMIT   = 300;
  localparam int PORT_LIMIT  = 50;

  logic     CLK;
  logic     nRST;
  mem_req_t req;
  logic     req_valid;
  logic     req_ready;
  logic     resp_valid;
  word_t    resp_data;
  logic     start;
  logic     halted;
  instr_t   prog [$];
  int       mismatches;
  int       failures;

  cpu_top DUT (
    .CLK(CLK), .nRST(nRST), .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .resp_valid(resp_valid), .resp_data(resp_data), .start(start), .halted(halted)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    #(TEST_CYCLES * 10 * 4);
    $display("watchdog expired before the tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic instr_t enc_r(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd,
                                   logic [4:0] sh);
    instr_t w;
    w.r_view.opcode = RTYPE;
    w.r_view.rs     = rs;
    w.r_view.rt     = rt;
    w.r_view.rd     = rd;
    w.r_view.shamt  = sh;
    w.r_view.funct  = f;
    return w;
  endfunction

  function automatic instr_t enc_i(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
    instr_t w;
    w.i_view.opcode = op;
    w.i_view.rs     = rs;
    w.i_view.rt     = rt;
    w.i_view.imm    = imm;
    return w;
  endfunction

  function automatic instr_t enc_j(opcode_t op, logic [25:0] addr);
    instr_t w;
    w.j_view.opcode = op;
    w.j_view.addr   = addr;
    return w;
  endfunction

  function automatic word_t sext16(logic [15:0] x);
    return {{16{x[15]}}, x};
  endfunction

  task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // request stays on the port until the accepting edge.
  task automatic send_req(mem_req_t r);
    int n;
    n = 0;
    @(posedge CLK);
    req       <= r;
    req_valid <= 1'b1;
    @(negedge CLK);
    while (!req_ready && n < PORT_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (!req_ready) begin
      failures++;
      $display("access port never accepted the request at %0t", $time);
    end
    @(posedge CLK);
    req_valid <= 1'b0;
  endtask

  task automatic port_write(space_t sp, word_t addr, word_t data);
    mem_req_t r;
    r.write = 1'b1;
    r.space = sp;
    r.addr  = addr;
    r.data  = data;
    send_req(r);
  endtask

  task automatic port_read(space_t sp, word_t addr, output word_t data);
    mem_req_t r;
    r.write = 1'b0;
    r.space = sp;
    r.addr  = addr;
    r.data  = '0;
    send_req(r);
    @(negedge CLK);
    check_flag(resp_valid, 1'b1, "resp_valid one cycle after acceptance");
    data = resp_data;
    @(negedge CLK);
    check_flag(resp_valid, 1'b0, "resp_valid lasts one cycle");
  endtask

  task automatic expect_dmem(word_t addr, word_t exp);
    word_t got;
    port_read(SPACE_DMEM, addr, got);
    check_word(got, exp, $sformatf("dmem[%h]", addr));
  endtask

  // program words go to imem from address 0.
  task automatic load_program();
    foreach (prog[i]) begin
      port_write(SPACE_IMEM, word_t'(i * 4), word_t'(prog[i]));
    end
    prog.delete();
  endtask

  task automatic run_program();
    int n;
    n = 0;
    load_program();
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    @(negedge CLK);
    check_flag(halted, 1'b0, "halted clears on start");
    while (!halted && n < RUN_LIMIT) begin
      check_flag(req_ready, 1'b0, "req_ready low while running");
      @(negedge CLK);
      n++;
    end
    if (!halted) begin
      failures++;
      $display("program did not halt within %0d cycles", RUN_LIMIT);
    end
  endtask

  task automatic port_access();
    word_t  data [8];
    word_t  got;
    space_t sp;
    @(negedge CLK);
    check_flag(req_ready, 1'b1, "req_ready while idle");
    for (int i = 0; i < 8; i++) begin
      data[i] = $urandom;
      sp = (i < 4) ? SPACE_IMEM : SPACE_DMEM;
      port_write(sp, 32'h200 + word_t'(i * 4), data[i]);
    end
    for (int i = 0; i < 8; i++) begin
      sp = (i < 4) ? SPACE_IMEM : SPACE_DMEM;
      port_read(sp, 32'h200 + word_t'(i * 4), got);
      check_word(got, data[i], $sformatf("port read back, word %0d", i));
    end
  endtask

  // dependent chain, each result stored at 0x40 + 4*reg.
  task automatic alu_chain();
    logic [15:0] ia, ib, iu, io;
    logic [4:0]  sh;
    word_t       e [11];
    ia = 16'($urandom);
    ib = 16'($urandom);
    iu = 16'($urandom);
    io = 16'($urandom);
    sh = 5'($urandom);
    prog.push_back(enc_i(ADDIU, 5'd0, 5'd1, ia));
    prog.push_back(enc_i(ADDIU, 5'd1, 5'd2, ib));
    prog.push_back(enc_r(ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    prog.push_back(enc_r(SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
    prog.push_back(enc_r(AND, 5'd4, 5'd2, 5'd5, 5'd0));
    prog.push_back(enc_r(OR, 5'd5, 5'd3, 5'd6, 5'd0));
    prog.push_back(enc_r(SLT, 5'd4, 5'd6, 5'd7, 5'd0));
    prog.push_back(enc_r(SLL, 5'd0, 5'd6, 5'd8, sh));
    prog.push_back(enc_i(LUI, 5'd0, 5'd9, iu));
    prog.push_back(enc_i(ORI, 5'd9, 5'd10, io));
    for (int r = 1; r <= 10; r++) begin
      prog.push_back(enc_i(SW, 5'd0, regbits_t'(r), 16'h0040 + 16'(r * 4)));
    end
    prog.push_back(enc_j(HALT, '0));
    e[0]  = '0;
    e[1]  = sext16(ia);
    e[2]  = e[1] + sext16(ib);
    e[3]  = e[1] + e[2];
    e[4]  = e[3] - e[1];
    e[5]  = e[4] & e[2];
    e[6]  = e[5] | e[3];
    e[7]  = ($signed(e[4]) < $signed(e[6])) ? 32'd1 : 32'd0;
    e[8]  = e[6] << sh;
    e[9]  = {iu, 16'h0000};
    e[10] = e[9] | {16'h0000, io};
    run_program();
    for (int r = 1; r <= 10; r++) begin
      expect_dmem(32'h40 + word_t'(r * 4), e[r]);
    end
  endtask

  task automatic load_use();
    word_t       v;
    logic [15:0] k;
    v = $urandom;
    k = 16'($urandom);
    port_write(SPACE_DMEM, 32'h80, v);
    prog.push_back(enc_i(ADDIU, 5'd0, 5'd1, k));
    prog.push_back(enc_i(LW, 5'd0, 5'd2, 16'h0080));
    prog.push_back(enc_r(ADDU, 5'd2, 5'd1, 5'd3, 5'd0));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h0084));
    prog.push_back(enc_i(LW, 5'd0, 5'd4, 16'h0084));
    prog.push_back(enc_i(SW, 5'd0, 5'd4, 16'h0088));
    prog.push_back(enc_j(HALT, '0));
    run_program();
    expect_dmem(32'h84, v + sext16(k));
    expect_dmem(32'h88, v + sext16(k));
  endtask

  // squashed stores write marker 0x77 into slots that must stay zero.
  task automatic control_flow();
    word_t flow [11];
    foreach (flow[i]) begin
      flow[i] = '0;
      port_write(SPACE_DMEM, 32'hA0 + word_t'(i * 4), '0);
    end
    flow[3] = 32'd5;
    flow[5] = 32'd5;
    // JAL sits at word 16.
    flow[8] = 32'd68;
    prog.push_back(enc_i(ADDIU, 5'd0, 5'd1, 16'd5));
    prog.push_back(enc_i(ADDIU, 5'd0, 5'd2, 16'd5));
    prog.push_back(enc_i(ADDIU, 5'd0, 5'd3, 16'h0077));
    prog.push_back(enc_i(BEQ, 5'd1, 5'd2, 16'd3));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00A0));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00A4));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00A8));
    prog.push_back(enc_i(BNE, 5'd1, 5'd2, 16'd1));
    prog.push_back(enc_i(SW, 5'd0, 5'd1, 16'h00AC));
    prog.push_back(enc_i(BNE, 5'd1, 5'd0, 16'd1));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00B0));
    prog.push_back(enc_i(BEQ, 5'd1, 5'd0, 16'd1));
    prog.push_back(enc_i(SW, 5'd0, 5'd2, 16'h00B4));
    prog.push_back(enc_j(J, 26'd16));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00B8));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00BC));
    prog.push_back(enc_j(JAL, 26'd20));
    prog.push_back(enc_i(SW, 5'd0, 5'd31, 16'h00C0));
    prog.push_back(enc_j(J, 26'd22));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00C4));
    prog.push_back(enc_r(JR, 5'd31, 5'd0, 5'd0, 5'd0));
    prog.push_back(enc_i(SW, 5'd0, 5'd3, 16'h00C8));
    prog.push_back(enc_j(HALT, '0));
    run_program();
    foreach (flow[i]) begin
      expect_dmem(32'hA0 + word_t'(i * 4), flow[i]);
    end
  endtask

  task automatic halt_restart();
    word_t       v1, v2;
    logic [15:0] k;
    v1 = $urandom;
    v2 = $urandom;
    k  = 16'($urandom);
    port_write(SPACE_DMEM, 32'h90, v1);
    prog.push_back(enc_i(LW, 5'd0, 5'd1, 16'h0090));
    prog.push_back(enc_i(ADDIU, 5'd1, 5'd2, k));
    prog.push_back(enc_i(SW, 5'd0, 5'd2, 16'h0094));
    prog.push_back(enc_j(HALT, '0));
    run_program();
    repeat (5) @(negedge CLK);
    check_flag(halted, 1'b1, "halted holds after halt");
    expect_dmem(32'h94, v1 + sext16(k));
    // same program again from PC 0 on new data.
    port_write(SPACE_DMEM, 32'h90, v2);
    run_program();
    expect_dmem(32'h94, v2 + sext16(k));
    check_flag(halted, 1'b1, "halted holds after second run");
  endtask

  initial begin
    void'($urandom(32'h2359_267d));
    mismatches = 0;
    failures   = 0;
    nRST       = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    start      = 1'b0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_flag(req_ready, 1'b1, "req_ready after reset");
    check_flag(resp_valid, 1'b0, "resp_valid after reset");
    check_flag(halted, 1'b0, "halted after reset");
    port_access();
    alu_chain();
    load_use();
    control_flow();
    halt_restart();
    $display("mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_macros.svh"

module cpu_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::mem_req_t req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output logic                    resp_valid,
  output cpu_types_pkg::word_t    resp_data,
  input  logic                    start,
  output logic                    halted
);
  import cpu_types_pkg::*;

  localparam int IMEM_AW = $clog2(`IMEM_DEPTH);
  localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

  word_t imem [`IMEM_DEPTH];
  word_t dmem [`DMEM_DEPTH];

  word_t              imem_addr, dmem_load, dmem_wdat;
  instr_t             imem_data;
  dmem_req_t          dmem_req;
  logic               run, restart, core_halt, port_accept, dmem_we;
  logic [DMEM_AW-1:0] dmem_widx;

  assign port_accept = req_valid && req_ready;

  // word-addressed arrays, byte addresses from outside.
  assign imem_data = instr_t'(imem[imem_addr[IMEM_AW+1:2]]);
  assign dmem_load = dmem[dmem_req.addr[DMEM_AW+1:2]];

  // core has the data memory while running.
  assign dmem_we   = run ? dmem_req.wen
                         : (port_accept && req.write && req.space == SPACE_DMEM);
  assign dmem_widx = run ? dmem_req.addr[DMEM_AW+1:2] : req.addr[DMEM_AW+1:2];
  assign dmem_wdat = run ? dmem_req.store : req.data;

  always_ff @(posedge CLK) begin
    if (port_accept && req.write && req.space == SPACE_IMEM) begin
      imem[req.addr[IMEM_AW+1:2]] <= req.data;
    end
    if (dmem_we) begin
      dmem[dmem_widx] <= dmem_wdat;
    end
  end

  // read response, one cycle after acceptance.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= port_accept && !req.write;
    end
  end

  always_ff @(posedge CLK) begin
    if (port_accept && !req.write) begin
      resp_data <= (req.space == SPACE_IMEM) ? imem[req.addr[IMEM_AW+1:2]]
                                             : dmem[req.addr[DMEM_AW+1:2]];
    end
  end

  datapath u_dp (
    .CLK(CLK), .nRST(nRST), .run(run), .restart(restart),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_load(dmem_load), .core_halt(core_halt)
  );

  run_control u_run (
    .CLK(CLK), .nRST(nRST), .start(start), .core_halt(core_halt),
    .req_valid(req_valid), .req_ready(req_ready),
    .run(run), .restart(restart), .halted(halted)
  );

endmodule

`default_nettype wire

// File: logic/run_control.sv
`default_nettype none
`timescale 1ns/10ps

module run_control (
  input  logic CLK,
  input  logic nRST,
  input  logic start,
  input  logic core_halt,
  input  logic req_valid,
  output logic req_ready,
  output logic run,
  output logic restart,
  output logic halted
);

  typedef enum logic [1:0] {IDLE, RUNNING, STOPPED} state_t;

  state_t state, state_next;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE, STOPPED: if (start) state_next = RUNNING;
      RUNNING:       if (core_halt) state_next = STOPPED;
      default:       state_next = IDLE;
    endcase
  end

  // restart clears PC and latches in the cycle before running.
  assign restart = start && state != RUNNING;

  assign run       = (state == RUNNING);
  assign halted    = (state == STOPPED);
  // the port owns the memories while the core is idle or halted.
  assign req_ready = (state == IDLE) || (state == STOPPED);

  a_port_vs_run: assert property (@(posedge CLK) disable iff (!nRST) req_ready |-> !run);

  // a request parked at a running core is held until accepted.
  a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
    req_valid && run |=> req_valid);

endmodule

`default_nettype wire

// File: logic/datapath.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_macros.svh"

module datapath (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     run,
  input  logic                     restart,
  output cpu_types_pkg::word_t     imem_addr,
  input  cpu_types_pkg::instr_t    imem_data,
  output cpu_types_pkg::dmem_req_t dmem_req,
  input  cpu_types_pkg::word_t     dmem_load,
  output logic                     core_halt
);
  import cpu_types_pkg::*;

  word_t    pc, pc4;
  if_id_t   if_id;
  id_ex_t   id_ex, id_ex_next;
  ex_mem_t  ex_mem, ex_mem_next;
  mem_wb_t  mem_wb, mem_wb_next;
  ctrl_t    id_ctrl;
  word_t    id_imm, rdat1, rdat2;
  word_t    fwd_a_val, fwd_b_val, alu_b, alu_out, ex_target;
  word_t    mem_fwd_val;
  logic     alu_zero, mem_taken, mem_redirect, stall, flush;
  regbits_t ex_dest;
  fwd_sel_t fwd_a, fwd_b;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t own);
    case (sel)
      FWD_EXMEM: return mem_fwd_val;
      FWD_MEMWB: return mem_wb.wdat;
      default:   return own;
    endcase
  endfunction

  // fetch.
  assign pc4       = pc + 32'd4;
  assign imem_addr = pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= `PC_INIT;
    end else if (restart) begin
      pc <= `PC_INIT;
    end else if (run && !stall) begin
      pc <= flush ? ex_mem.target : pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      if_id <= '0;
    end else if (restart || (run && flush)) begin
      if_id <= '0;
    end else if (run && !stall) begin
      if_id <= '{valid: 1'b1, instr: imem_data, pc4: pc4};
    end
  end

  // decode.
  control_unit u_ctrl (.instr(if_id.instr), .ctrl(id_ctrl));

  assign id_imm = id_ctrl.extsel ? {{16{if_id.instr.i_view.imm[15]}}, if_id.instr.i_view.imm}
                                 : {16'h0000, if_id.instr.i_view.imm};

  register_file u_rf (
    .CLK(CLK), .nRST(nRST),
    .wen(run && mem_wb.valid && mem_wb.reg_wen), .wsel(mem_wb.dest), .wdat(mem_wb.wdat),
    .rsel1(if_id.instr.r_view.rs), .rsel2(if_id.instr.r_view.rt),
    .rdat1(rdat1), .rdat2(rdat2)
  );

  always_comb begin
    id_ex_next.valid = if_id.valid;
    id_ex_next.ctrl  = if_id.valid ? id_ctrl : '0;
    id_ex_next.instr = if_id.instr;
    id_ex_next.pc4   = if_id.pc4;
    id_ex_next.rdat1 = rdat1;
    id_ex_next.rdat2 = rdat2;
    id_ex_next.imm32 = id_imm;
  end

  // execute.
  assign fwd_a_val = fwd_mux(fwd_a, id_ex.rdat1);
  assign fwd_b_val = fwd_mux(fwd_b, id_ex.rdat2);
  assign alu_b     = id_ex.ctrl.alusrc ? id_ex.imm32 : fwd_b_val;

  alu u_alu (
    .op(id_ex.ctrl.aluop), .a(fwd_a_val), .b(alu_b),
    .shamt(id_ex.instr.r_view.shamt), .result(alu_out), .zero(alu_zero)
  );

  always_comb begin
    case (id_ex.ctrl.regdst)
      REGDST_RD: ex_dest = id_ex.instr.r_view.rd;
      REGDST_RT: ex_dest = id_ex.instr.i_view.rt;
      REGDST_RA: ex_dest = 5'd31;
      default:   ex_dest = '0;
    endcase
  end

  // redirect target, used only if MEM decides to take it.
  always_comb begin
    case (id_ex.ctrl.pcsrc)
      PCSRC_REG:  ex_target = fwd_a_val;
      PCSRC_JUMP: ex_target = {id_ex.pc4[31:28], id_ex.instr.j_view.addr, 2'b00};
      PCSRC_BEQ,
      PCSRC_BNE:  ex_target = id_ex.pc4 + (id_ex.imm32 << 2);
      default:    ex_target = id_ex.pc4;
    endcase
  end

  always_comb begin
    ex_mem_next.valid   = id_ex.valid;
    ex_mem_next.ctrl    = id_ex.ctrl;
    ex_mem_next.pc4     = id_ex.pc4;
    ex_mem_next.alu_out = alu_out;
    ex_mem_next.store   = fwd_b_val;
    ex_mem_next.target  = ex_target;
    ex_mem_next.dest    = ex_dest;
    ex_mem_next.zero    = alu_zero;
  end

  // memory.
  always_comb begin
    case (ex_mem.ctrl.pcsrc)
      PCSRC_REG, PCSRC_JUMP: mem_taken = 1'b1;
      PCSRC_BEQ:             mem_taken = ex_mem.zero;
      PCSRC_BNE:             mem_taken = !ex_mem.zero;
      default:               mem_taken = 1'b0;
    endcase
  end

  // halt also squashes the younger instructions.
  assign mem_redirect = ex_mem.valid && (mem_taken || ex_mem.ctrl.halt);

  assign dmem_req.ren   = ex_mem.valid && ex_mem.ctrl.dren;
  assign dmem_req.wen   = ex_mem.valid && ex_mem.ctrl.dwen;
  assign dmem_req.addr  = ex_mem.alu_out;
  assign dmem_req.store = ex_mem.store;

  assign mem_fwd_val = (ex_mem.ctrl.regsrc == REGSRC_PC4) ? ex_mem.pc4 : ex_mem.alu_out;

  always_comb begin
    mem_wb_next.valid   = ex_mem.valid;
    mem_wb_next.reg_wen = ex_mem.ctrl.reg_wen;
    mem_wb_next.halt    = ex_mem.ctrl.halt;
    mem_wb_next.dest    = ex_mem.dest;
    mem_wb_next.wdat    = (ex_mem.ctrl.regsrc == REGSRC_MEM) ? dmem_load : mem_fwd_val;
  end

  // stage latches behind IF/ID.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (restart) begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (run) begin
      id_ex  <= (flush || stall) ? '0 : id_ex_next;
      ex_mem <= flush ? '0 : ex_mem_next;
      mem_wb <= mem_wb_next;
    end
  end

  hazard_unit u_hazard (
    .id_rs(if_id.instr.r_view.rs), .id_rt(if_id.instr.r_view.rt),
    .ex_rs(id_ex.instr.r_view.rs), .ex_rt(id_ex.instr.r_view.rt),
    .ex_dest(ex_dest), .ex_is_load(id_ex.valid && id_ex.ctrl.dren),
    .mem_dest(ex_mem.dest), .mem_wen(ex_mem.valid && ex_mem.ctrl.reg_wen),
    .wb_dest(mem_wb.dest), .wb_wen(mem_wb.valid && mem_wb.reg_wen),
    .mem_redirect(mem_redirect),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
  );

  // writeback.
  assign core_halt = mem_wb.valid && mem_wb.halt;

  a_dmem_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.ren && dmem_req.wen));

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`default_nettype none
`timescale 1ns/10ps

module hazard_unit (
  input  cpu_types_pkg::regbits_t id_rs,
  input  cpu_types_pkg::regbits_t id_rt,
  input  cpu_types_pkg::regbits_t ex_rs,
  input  cpu_types_pkg::regbits_t ex_rt,
  input  cpu_types_pkg::regbits_t ex_dest,
  input  logic                    ex_is_load,
  input  cpu_types_pkg::regbits_t mem_dest,
  input  logic                    mem_wen,
  input  cpu_types_pkg::regbits_t wb_dest,
  input  logic                    wb_wen,
  input  logic                    mem_redirect,
  output cpu_types_pkg::fwd_sel_t fwd_a,
  output cpu_types_pkg::fwd_sel_t fwd_b,
  output logic                    stall,
  output logic                    flush
);
  import cpu_types_pkg::*;

  logic load_use;

  // the younger producer wins.
  function automatic fwd_sel_t pick(input regbits_t src);
    if (src == '0) begin
      return FWD_NONE;
    end
    if (mem_wen && mem_dest == src) begin
      return FWD_EXMEM;
    end
    if (wb_wen && wb_dest == src) begin
      return FWD_MEMWB;
    end
    return FWD_NONE;
  endfunction

  assign fwd_a = pick(ex_rs);
  assign fwd_b = pick(ex_rt);

  // loaded word is not ready until MEM/WB.
  assign load_use = ex_is_load && ex_dest != '0 && (ex_dest == id_rs || ex_dest == id_rt);

  // a redirect squashes the stalled instruction anyway.
  assign stall = load_use && !mem_redirect;
  assign flush = mem_redirect;

endmodule

`default_nettype wire

// File: logic/control_unit.sv
`default_nettype none
`timescale 1ns/10ps

module control_unit (
  input  cpu_types_pkg::instr_t instr,
  output cpu_types_pkg::ctrl_t  ctrl
);
  import cpu_types_pkg::*;

  always_comb begin
    // unknown encodings fall through as a no-op.
    ctrl = '0;
    case (instr.r_view.opcode)
      RTYPE: begin
        ctrl.regdst  = REGDST_RD;
        ctrl.reg_wen = 1'b1;
        case (instr.r_view.funct)
          ADDU: ctrl.aluop = ALU_ADD;
          SUBU: ctrl.aluop = ALU_SUB;
          AND:  ctrl.aluop = ALU_AND;
          OR:   ctrl.aluop = ALU_OR;
          SLT:  ctrl.aluop = ALU_SLT;
          SLL:  ctrl.aluop = ALU_SLL;
          JR: begin
            ctrl.pcsrc   = PCSRC_REG;
            ctrl.reg_wen = 1'b0;
          end
          default: ctrl.reg_wen = 1'b0;
        endcase
      end
      ADDIU, LW, SW: begin
        ctrl.aluop   = ALU_ADD;
        ctrl.alusrc  = 1'b1;
        ctrl.extsel  = 1'b1;
        ctrl.regdst  = REGDST_RT;
        ctrl.reg_wen = (instr.r_view.opcode != SW);
        ctrl.dren    = (instr.r_view.opcode == LW);
        ctrl.dwen    = (instr.r_view.opcode == SW);
        ctrl.regsrc  = (instr.r_view.opcode == LW) ? REGSRC_MEM : REGSRC_ALU;
      end
      ORI, LUI: begin
        // zero extended immediate.
        ctrl.aluop   = (instr.r_view.opcode == ORI) ? ALU_OR : ALU_LUI;
        ctrl.alusrc  = 1'b1;
        ctrl.regdst  = REGDST_RT;
        ctrl.reg_wen = 1'b1;
      end
      BEQ, BNE: begin
        ctrl.aluop  = ALU_SUB;
        ctrl.extsel = 1'b1;
        ctrl.pcsrc  = (instr.r_view.opcode == BEQ) ? PCSRC_BEQ : PCSRC_BNE;
      end
      J: ctrl.pcsrc = PCSRC_JUMP;
      JAL: begin
        ctrl.pcsrc   = PCSRC_JUMP;
        ctrl.regdst  = REGDST_RA;
        ctrl.regsrc  = REGSRC_PC4;
        ctrl.reg_wen = 1'b1;
      end
      HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`default_nettype none
`timescale 1ns/10ps

`include "cpu_macros.svh"

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [`REG_CNT];

  // write-through so ID sees the value written back this cycle.
  function automatic word_t read_port(input regbits_t sel);
    if (sel == '0) begin
      return '0;
    end
    if (wen && wsel == sel) begin
      return wdat;
    end
    return regs[sel];
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = read_port(rsel1);
  assign rdat2 = read_port(rsel2);

  a_zero_reg: assert property (@(posedge CLK) disable iff (!nRST) regs[0] == '0);

endmodule

`default_nettype wire

// File: logic/alu.sv
`default_nettype none
`timescale 1ns/10ps

module alu (
  input  cpu_types_pkg::aluop_t op,
  input  cpu_types_pkg::word_t  a,
  input  cpu_types_pkg::word_t  b,
  input  logic [4:0]            shamt,
  output cpu_types_pkg::word_t  result,
  output logic                  zero
);
  import cpu_types_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // signed compare.
      ALU_SLT: result = word_t'($signed(a) < $signed(b));
      ALU_SLL: result = b << shamt;
      ALU_LUI: result = {b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  // branches compare through the subtract result.
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: logic/cpu_types_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [4:0] regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'h00,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI} aluop_t;
  typedef enum logic [1:0] {REGSRC_ALU, REGSRC_MEM, REGSRC_PC4} regsrc_t;
  typedef enum logic [1:0] {REGDST_RD, REGDST_RT, REGDST_RA} regdst_t;
  typedef enum logic [2:0] {PCSRC_PC4, PCSRC_REG, PCSRC_JUMP, PCSRC_BEQ, PCSRC_BNE} pcsrc_t;
  typedef enum logic [1:0] {FWD_NONE, FWD_EXMEM, FWD_MEMWB} fwd_sel_t;
  typedef enum logic {SPACE_IMEM, SPACE_DMEM} space_t;

  // one instruction word, three field layouts.
  typedef struct packed {
    opcode_t    opcode;
    regbits_t   rs;
    regbits_t   rt;
    regbits_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_view_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm;
  } i_view_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr;
  } j_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    j_view_t j_view;
  } instr_t;

  typedef struct packed {
    aluop_t  aluop;
    logic    alusrc;
    logic    extsel;
    regsrc_t regsrc;
    regdst_t regdst;
    pcsrc_t  pcsrc;
    logic    reg_wen;
    logic    dren;
    logic    dwen;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
    word_t  pc4;
  } if_id_t;

  typedef struct packed {
    logic   valid;
    ctrl_t  ctrl;
    instr_t instr;
    word_t  pc4;
    word_t  rdat1;
    word_t  rdat2;
    word_t  imm32;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    pc4;
    word_t    alu_out;
    word_t    store;
    word_t    target;
    regbits_t dest;
    logic     zero;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_wen;
    logic     halt;
    regbits_t dest;
    word_t    wdat;
  } mem_wb_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } dmem_req_t;

  // addr is a byte address, word aligned.
  typedef struct packed {
    logic   write;
    space_t space;
    word_t  addr;
    word_t  data;
  } mem_req_t;

endpackage

`default_nettype wire

// File: logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word width.
`define WORD_W 32

// architectural register count.
`define REG_CNT 32

// memory depths in words.
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// program counter after reset or restart.
`define PC_INIT 32'h0000_0000

`endif
